// File: src/conv_params.svh
/* widths, tap count and APB register map of the 3x3 engine
   lines wider than CONV_MAX_WIDTH pixels are not supported */
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

`define CONV_PIX_W      16
`define CONV_COEF_W     16
`define CONV_TAPS       9
`define CONV_MAX_WIDTH  64
`define CONV_COL_W      6
`define CONV_ADDR_W     32
`define CONV_APB_AW     8
`define CONV_SHIFT_W    5

// APB register offsets
`define CONV_REG_CTRL   8'h00
`define CONV_REG_BASE   8'h04
`define CONV_REG_WIDTH  8'h08
`define CONV_REG_QF     8'h0C
`define CONV_REG_FLAGS  8'h10
`define CONV_REG_STATUS 8'h14

`endif

// File: src/conv_pkg.sv
/* data types of the 3x3 engine; pixels, coefficients and results are signed */
`include "conv_params.svh"

package conv_pkg;

  ////////////////////////////////////////
  // scalar types
  ////////////////////////////////////////

  typedef logic signed [`CONV_PIX_W-1:0]  pixel_t;
  typedef logic signed [`CONV_COEF_W-1:0] coef_t;

  // saturated output sample
  typedef logic signed [`CONV_PIX_W-1:0]  result_t;

  ////////////////////////////////////////
  // window and coefficient sets
  ////////////////////////////////////////

  // tap k = 3*row + col
  // row 0 is the oldest line, col 0 the oldest pixel of the row
  typedef pixel_t [`CONV_TAPS-1:0] window_t;

  // same tap order as window_t, as read from memory words 0..8
  typedef coef_t [`CONV_TAPS-1:0] coef_set_t;

endpackage

// File: src/stream_skid_buffer.sv
/* two-entry valid/ready stage; in_ready_o is the registered out_ready_i,
   so it is low after reset and until the consumer signals ready */
module stream_skid_buffer #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_fast_i,
  input  logic     rst_n,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  input  logic     out_ready_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o
);

  payload_t skid_data_q;
  logic     skid_valid_q;
  logic     in_fire, main_free, main_ld_skid, main_ld_in, skid_ld;

  assign in_fire      = in_valid_i & in_ready_o;
  assign main_free    = ~out_valid_o | out_ready_i;
  assign main_ld_skid = main_free & skid_valid_q;
  assign main_ld_in   = main_free & ~skid_valid_q & in_fire;
  // item taken in the cycle the consumer dropped ready
  assign skid_ld      = in_fire & ~main_ld_in;

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      in_ready_o   <= 1'b0;
      out_valid_o  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      in_ready_o   <= out_ready_i;
      out_valid_o  <= ~main_free | skid_valid_q | in_fire;
      skid_valid_q <= skid_ld | (skid_valid_q & ~main_free);
    end
  end

  always_ff @(posedge clk_fast_i) begin
    if (main_ld_skid)    out_data_o <= skid_data_q;
    else if (main_ld_in) out_data_o <= in_data_i;
    if (skid_ld) skid_data_q <= in_data_i;
  end

endmodule

// File: src/conv_cfg_apb.sv
/* zero-wait APB register file; unmapped offsets and STATUS writes raise pslverr
   CTRL bits are self-clearing pulses and always read back as 0 */
`include "conv_params.svh"

module conv_cfg_apb (
  input  logic                     clk_fast_i,
  input  logic                     rst_n,
  input  logic                     apb_psel_i,
  input  logic                     apb_penable_i,
  input  logic                     apb_pwrite_i,
  input  logic [`CONV_APB_AW-1:0]  apb_paddr_i,
  input  logic [31:0]              apb_pwdata_i,
  input  logic                     weights_ready_i,
  input  logic                     busy_i,
  output logic [31:0]              apb_prdata_o,
  output logic                     apb_pready_o,
  output logic                     apb_pslverr_o,
  output logic                     load_start_o,
  output logic                     frame_clear_o,
  output logic [`CONV_ADDR_W-1:0]  base_addr_o,
  output logic [`CONV_COL_W:0]     line_width_o,
  output logic [`CONV_SHIFT_W-1:0] shift_o,
  output logic                     relu_o
);

  logic acc_phase;
  logic wr_en;
  logic hit_ctrl, hit_base, hit_width, hit_qf, hit_flags, hit_status;

  assign acc_phase = apb_psel_i & apb_penable_i;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  always_comb begin
    hit_ctrl   = (apb_paddr_i == `CONV_REG_CTRL);
    hit_base   = (apb_paddr_i == `CONV_REG_BASE);
    hit_width  = (apb_paddr_i == `CONV_REG_WIDTH);
    hit_qf     = (apb_paddr_i == `CONV_REG_QF);
    hit_flags  = (apb_paddr_i == `CONV_REG_FLAGS);
    hit_status = (apb_paddr_i == `CONV_REG_STATUS);
  end

  // no wait states
  assign apb_pready_o  = acc_phase;
  assign apb_pslverr_o = acc_phase &
                         (~(hit_ctrl | hit_base | hit_width | hit_qf | hit_flags | hit_status) |
                          (apb_pwrite_i & hit_status));
  assign wr_en = acc_phase & apb_pwrite_i & ~apb_pslverr_o;

  // read mux
  always_comb begin
    apb_prdata_o = '0;
    if (hit_base)   apb_prdata_o = base_addr_o;
    if (hit_width)  apb_prdata_o = 32'(line_width_o);
    if (hit_qf)     apb_prdata_o = 32'(shift_o);
    if (hit_flags)  apb_prdata_o = {31'b0, relu_o};
    if (hit_status) apb_prdata_o = {30'b0, busy_i, weights_ready_i};
  end

  ////////////////////////////////////////
  // registers and CTRL pulses
  ////////////////////////////////////////

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      load_start_o  <= 1'b0;
      frame_clear_o <= 1'b0;
      base_addr_o   <= '0;
      line_width_o  <= (`CONV_COL_W+1)'(`CONV_MAX_WIDTH);
      shift_o       <= '0;
      relu_o        <= 1'b0;
    end else begin
      load_start_o  <= wr_en & hit_ctrl & apb_pwdata_i[0];
      frame_clear_o <= wr_en & hit_ctrl & apb_pwdata_i[1];
      if (wr_en & hit_base)  base_addr_o  <= apb_pwdata_i;
      if (wr_en & hit_width) line_width_o <= apb_pwdata_i[`CONV_COL_W:0];
      if (wr_en & hit_qf)    shift_o      <= apb_pwdata_i[`CONV_SHIFT_W-1:0];
      if (wr_en & hit_flags) relu_o       <= apb_pwdata_i[0];
    end
  end

endmodule

// File: src/conv_weight_loader.sv
/* reads 9 coefficients and a bias, one request outstanding at a time
   a new start while a read is still outstanding is not supported */
`include "conv_params.svh"

module conv_weight_loader (
  input  logic                    clk_fast_i,
  input  logic                    rst_n,
  input  logic                    load_start_i,
  input  logic [`CONV_ADDR_W-1:0] base_addr_i,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  logic [31:0]             mem_rdata_i,
  output logic                    mem_req_o,
  output logic [`CONV_ADDR_W-1:0] mem_addr_o,
  output conv_pkg::coef_set_t     coefs_o,
  output conv_pkg::coef_t         bias_o,
  output logic                    weights_ready_o,
  output logic                    busy_o,
  output logic                    done_o
);

  typedef enum logic [1:0] {LD_IDLE, LD_REQ, LD_WAIT} ld_state_e;

  ld_state_e              state_q;
  logic [3:0]             word_q;
  logic [`CONV_ADDR_W-1:0] base_q;
  logic                   last_word;
  logic                   store;

  // word 9 is the bias
  assign last_word  = (word_q == 4'(`CONV_TAPS));
  assign store      = (state_q == LD_WAIT) & mem_rvalid_i & ~load_start_i;
  assign mem_req_o  = (state_q == LD_REQ);
  assign mem_addr_o = base_q + (`CONV_ADDR_W'(word_q) << 2);
  assign busy_o     = (state_q != LD_IDLE);

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q         <= LD_IDLE;
      word_q          <= '0;
      weights_ready_o <= 1'b0;
      done_o          <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (load_start_i) begin
        state_q         <= LD_REQ;
        word_q          <= '0;
        weights_ready_o <= 1'b0;
      end else begin
        case (state_q)
          LD_REQ:  if (mem_gnt_i) state_q <= LD_WAIT;
          LD_WAIT: if (mem_rvalid_i) begin
            if (last_word) begin
              state_q         <= LD_IDLE;
              weights_ready_o <= 1'b1;
              done_o          <= 1'b1;
            end else begin
              word_q  <= word_q + 4'd1;
              state_q <= LD_REQ;
            end
          end
          default: state_q <= LD_IDLE;
        endcase
      end
    end
  end

  // coefficient storage, low half of each word
  always_ff @(posedge clk_fast_i) begin
    if (load_start_i) base_q <= base_addr_i;
    if (store) begin
      if (last_word) bias_o <= conv_pkg::coef_t'(mem_rdata_i[15:0]);
      else           coefs_o[word_q] <= conv_pkg::coef_t'(mem_rdata_i[15:0]);
    end
  end

endmodule

// File: src/conv_window_gen.sv
/* 3x3 window over a raster pixel stream, valid convolution only (row, col >= 2)
   line_width_i must be 3..CONV_MAX_WIDTH and stay fixed during a frame */
`include "conv_params.svh"

module conv_window_gen (
  input  logic                  clk_fast_i,
  input  logic                  rst_n,
  input  logic                  frame_clear_i,
  input  logic [`CONV_COL_W:0]  line_width_i,
  input  logic                  pix_valid_i,
  input  conv_pkg::pixel_t      pix_data_i,
  input  logic                  win_ready_i,
  output logic                  pix_ready_o,
  output logic                  win_valid_o,
  output conv_pkg::window_t     win_data_o
);

  // line0 holds the previous row, line1 the row before it
  conv_pkg::pixel_t       line0_mem [`CONV_MAX_WIDTH];
  conv_pkg::pixel_t       line1_mem [`CONV_MAX_WIDTH];
  conv_pkg::pixel_t       win_q [3][3];
  conv_pkg::pixel_t       col_new [3];
  logic [`CONV_COL_W-1:0] col_q;
  logic [1:0]             row_q;
  logic                   accept;
  logic                   last_col;

  // win_ready_i is only high when the SOP unit holds weights and can take
  // a window, so the output register is then empty or being drained
  assign pix_ready_o = win_ready_i;
  assign accept      = pix_valid_i & pix_ready_o;
  assign last_col    = ({1'b0, col_q} == line_width_i - 1'b1);

  // new column entering the window, oldest row first
  always_comb begin
    col_new[0] = line1_mem[col_q];
    col_new[1] = line0_mem[col_q];
    col_new[2] = pix_data_i;
  end

  ////////////////////////////////////////
  // position counters and window valid
  ////////////////////////////////////////

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_o <= 1'b0;
    end else begin
      if (frame_clear_i) begin
        col_q <= '0;
        row_q <= '0;
      end else if (accept) begin
        if (last_col) begin
          col_q <= '0;
          if (row_q != 2'd2) row_q <= row_q + 2'd1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
      if (accept)           win_valid_o <= (row_q == 2'd2) && (col_q >= 2);
      else if (win_ready_i) win_valid_o <= 1'b0;
    end
  end

  // line memories and shift window
  always_ff @(posedge clk_fast_i) begin
    if (accept) begin
      line1_mem[col_q] <= line0_mem[col_q];
      line0_mem[col_q] <= pix_data_i;
      for (int r = 0; r < 3; r++) begin
        win_q[r][0] <= win_q[r][1];
        win_q[r][1] <= win_q[r][2];
        win_q[r][2] <= col_new[r];
      end
    end
  end

  always_comb begin
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        win_data_o[3*r+c] = win_q[r][c];
      end
    end
  end

endmodule

// File: src/conv_sop.sv
/* two-stage sum of products: (sum >>> shift) + bias, optional ReLU, 16-bit saturation
   windows are only taken once the weights are loaded */
`include "conv_params.svh"

module conv_sop (
  input  logic                     clk_fast_i,
  input  logic                     rst_n,
  input  logic                     win_valid_i,
  input  conv_pkg::window_t        win_data_i,
  input  conv_pkg::coef_set_t      coefs_i,
  input  conv_pkg::coef_t          bias_i,
  input  logic                     weights_ready_i,
  input  logic [`CONV_SHIFT_W-1:0] shift_i,
  input  logic                     relu_i,
  input  logic                     res_ready_i,
  output logic                     win_ready_o,
  output logic                     res_valid_o,
  output conv_pkg::result_t        res_data_o
);

  localparam int PROD_W = `CONV_PIX_W + `CONV_COEF_W;
  // four guard bits cover the nine-term sum
  localparam int ACC_W  = PROD_W + 4;
  localparam logic signed [ACC_W-1:0] RES_MAX = 32767;
  localparam logic signed [ACC_W-1:0] RES_MIN = -32768;

  logic signed [PROD_W-1:0] prod_q [`CONV_TAPS];
  logic signed [ACC_W-1:0]  sum_c, shifted_c, biased_c;
  conv_pkg::result_t        result_c;
  logic                     s1_valid_q;
  logic                     s1_free, s2_free, win_fire;

  assign s2_free     = ~res_valid_o | res_ready_i;
  assign s1_free     = ~s1_valid_q | s2_free;
  assign win_ready_o = weights_ready_i & s1_free;
  assign win_fire    = win_valid_i & win_ready_o;

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q  <= 1'b0;
      res_valid_o <= 1'b0;
    end else begin
      if (s1_free) s1_valid_q  <= win_fire;
      if (s2_free) res_valid_o <= s1_valid_q;
    end
  end

  ////////////////////////////////////////
  // stage 2 arithmetic
  ////////////////////////////////////////

  always_comb begin
    sum_c = '0;
    for (int k = 0; k < `CONV_TAPS; k++) sum_c = sum_c + prod_q[k];
    shifted_c = sum_c >>> shift_i;
    biased_c  = shifted_c + bias_i;
    if (relu_i && biased_c < 0) result_c = '0;
    else if (biased_c > RES_MAX) result_c = 16'sh7fff;
    else if (biased_c < RES_MIN) result_c = 16'sh8000;
    else result_c = biased_c[15:0];
  end

  always_ff @(posedge clk_fast_i) begin
    if (win_fire) begin
      for (int k = 0; k < `CONV_TAPS; k++) begin
        prod_q[k] <= $signed(win_data_i[k]) * $signed(coefs_i[k]);
      end
    end
    if (s2_free && s1_valid_q) res_data_o <= result_c;
  end

endmodule

// File: src/conv_top.sv
/* streaming 3x3 convolution engine, single clock domain
   configuration must not change while a frame is streaming */
`include "conv_params.svh"

module conv_top (
  input  logic                    clk_fast_i,
  input  logic                    rst_n,
  // APB slave
  input  logic                    apb_psel_i,
  input  logic                    apb_penable_i,
  input  logic                    apb_pwrite_i,
  input  logic [`CONV_APB_AW-1:0] apb_paddr_i,
  input  logic [31:0]             apb_pwdata_i,
  output logic [31:0]             apb_prdata_o,
  output logic                    apb_pready_o,
  output logic                    apb_pslverr_o,
  // weight memory read port
  output logic                    mem_req_o,
  output logic [`CONV_ADDR_W-1:0] mem_addr_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  logic [31:0]             mem_rdata_i,
  // pixel and result streams
  input  logic                    pix_valid_i,
  output logic                    pix_ready_o,
  input  conv_pkg::pixel_t        pix_data_i,
  output logic                    res_valid_o,
  input  logic                    res_ready_i,
  output conv_pkg::result_t       res_data_o,
  output logic                    evt_o
);

  logic                     load_start, frame_clear, relu, weights_ready, busy;
  logic [`CONV_ADDR_W-1:0]  base_addr;
  logic [`CONV_COL_W:0]     line_width;
  logic [`CONV_SHIFT_W-1:0] shift;
  conv_pkg::coef_set_t      coefs;
  conv_pkg::coef_t          bias;
  logic                     px_valid, px_ready, win_valid, win_ready, sop_valid, sop_ready;
  conv_pkg::pixel_t         px_data;
  conv_pkg::window_t        win_data;
  conv_pkg::result_t        sop_data;

  conv_cfg_apb cfg0 (
    .clk_fast_i, .rst_n,
    .apb_psel_i, .apb_penable_i, .apb_pwrite_i, .apb_paddr_i, .apb_pwdata_i,
    .weights_ready_i (weights_ready), .busy_i (busy),
    .apb_prdata_o, .apb_pready_o, .apb_pslverr_o,
    .load_start_o (load_start), .frame_clear_o (frame_clear), .base_addr_o (base_addr),
    .line_width_o (line_width), .shift_o (shift), .relu_o (relu)
  );

  conv_weight_loader loader0 (
    .clk_fast_i, .rst_n,
    .load_start_i (load_start), .base_addr_i (base_addr),
    .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i, .mem_req_o, .mem_addr_o,
    .coefs_o (coefs), .bias_o (bias), .weights_ready_o (weights_ready),
    .busy_o (busy), .done_o (evt_o)
  );

  stream_skid_buffer #(.payload_t(conv_pkg::pixel_t)) pix_skid (
    .clk_fast_i, .rst_n,
    .in_valid_i (pix_valid_i), .in_data_i (pix_data_i), .in_ready_o (pix_ready_o),
    .out_valid_o (px_valid), .out_data_o (px_data), .out_ready_i (px_ready)
  );

  conv_window_gen wingen0 (
    .clk_fast_i, .rst_n,
    .frame_clear_i (frame_clear), .line_width_i (line_width),
    .pix_valid_i (px_valid), .pix_data_i (px_data), .pix_ready_o (px_ready),
    .win_valid_o (win_valid), .win_data_o (win_data), .win_ready_i (win_ready)
  );

  conv_sop sop0 (
    .clk_fast_i, .rst_n,
    .win_valid_i (win_valid), .win_data_i (win_data), .win_ready_o (win_ready),
    .coefs_i (coefs), .bias_i (bias), .weights_ready_i (weights_ready),
    .shift_i (shift), .relu_i (relu),
    .res_valid_o (sop_valid), .res_data_o (sop_data), .res_ready_i (sop_ready)
  );

  stream_skid_buffer #(.payload_t(conv_pkg::result_t)) res_skid (
    .clk_fast_i, .rst_n,
    .in_valid_i (sop_valid), .in_data_i (sop_data), .in_ready_o (sop_ready),
    .out_valid_o (res_valid_o), .out_data_o (res_data_o), .out_ready_i (res_ready_i)
  );

endmodule

// File: verification/tb_conv_top.sv
/* self-checking testbench for conv_top with a reference model of the convolution
   frames are at most 64 pixels wide and 6 rows high; stimulus is seeded for repeatability */
`include "conv_params.svh"

module tb_conv_top;

  localparam int MAX_PIXELS   = 6 * `CONV_MAX_WIDTH * 6;
  // worst case stall per pixel with gaps and result back-pressure
  localparam int STALL_FACTOR = 16;
  localparam int WD_CYCLES    = MAX_PIXELS * STALL_FACTOR + 5000;

  logic                    clk_fast_i;
  logic                    rst_n;
  logic                    apb_psel_i, apb_penable_i, apb_pwrite_i;
  logic [`CONV_APB_AW-1:0] apb_paddr_i;
  logic [31:0]             apb_pwdata_i, apb_prdata_o;
  logic                    apb_pready_o, apb_pslverr_o;
  logic                    mem_req_o, mem_gnt_i, mem_rvalid_i;
  logic [`CONV_ADDR_W-1:0] mem_addr_o;
  logic [31:0]             mem_rdata_i;
  logic                    pix_valid_i, pix_ready_o, res_valid_o, res_ready_i, evt_o;
  conv_pkg::pixel_t        pix_data_i;
  conv_pkg::result_t       res_data_o;

  int          seed;
  int          errors;
  int          results;
  int          evt_cnt = 0;
  int          req_n;
  logic [31:0] exp_base;
  shortint     coef [9];
  shortint     bias_w;
  int          cur_shift;
  logic        cur_relu;
  shortint     img [$];
  int          exp_q [$];

  conv_top dut0 (.*);

  initial clk_fast_i = 1'b0;
  always #5 clk_fast_i = ~clk_fast_i;

  // evt_o is a single-cycle pulse
  always @(negedge clk_fast_i) begin
    if (rst_n && evt_o) evt_cnt <= evt_cnt + 1;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int rand_signed(int range);
    return rand_below(2 * range + 1) - range;
  endfunction

  function automatic void report_err(string name, longint exp, longint act);
    errors++;
    $display("ERR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
  endfunction

  function automatic void report_fail(string what);
    errors++;
    $display("at %0t: %s", $time, what);
  endfunction

  // window taps row major, oldest row and column first
  function automatic int model_result(int w, int y, int x);
    longint acc;
    longint val;
    acc = 0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        acc += longint'(img[(y - 2 + r) * w + x - 2 + c]) * longint'(coef[3 * r + c]);
      end
    end
    val = (acc >>> cur_shift) + longint'(bias_w);
    if (cur_relu && val < 0) val = 0;
    if (val > 32767) val = 32767;
    if (val < -32768) val = -32768;
    return int'(val);
  endfunction

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk_fast_i);
    #1;
    apb_psel_i    = 1'b1;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = wr;
    apb_paddr_i   = addr;
    apb_pwdata_i  = wdata;
    @(posedge clk_fast_i);
    #1;
    apb_penable_i = 1'b1;
    @(negedge clk_fast_i);
    rdata = apb_prdata_o;
    err   = apb_pslverr_o;
    if (apb_pready_o !== 1'b1) report_err("apb_pready_o", 1, apb_pready_o);
    @(posedge clk_fast_i);
    #1;
    apb_psel_i    = 1'b0;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    if (err !== 1'b0) report_err("apb_pslverr_o", 0, err);
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] rd);
    logic err;
    apb_access(1'b0, addr, 32'h0, rd, err);
    if (err !== 1'b0) report_err("apb_pslverr_o", 0, err);
  endtask

  task automatic reg_check(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    reg_read(addr, rd);
    if (rd !== exp) report_err("apb_prdata_o", exp, rd);
  endtask

  task automatic expect_slverr(input logic wr, input logic [7:0] addr);
    logic [31:0] rd;
    logic        err;
    apb_access(wr, addr, 32'hffff_ffff, rd, err);
    if (err !== 1'b1) report_err("apb_pslverr_o", 1, err);
  endtask

  task automatic set_qf(input int shift, input logic relu);
    cur_shift = shift;
    cur_relu  = relu;
    reg_write(`CONV_REG_QF, 32'(shift));
    reg_write(`CONV_REG_FLAGS, {31'b0, relu});
  endtask

  task automatic pick_weights(input bit big);
    for (int k = 0; k < 9; k++) begin
      coef[k] = big ? shortint'($random(seed)) : shortint'(rand_signed(31));
    end
    bias_w = big ? shortint'($random(seed)) : shortint'(rand_signed(500));
  endtask

  task automatic load_weights(input logic [31:0] base);
    int          evt_before;
    logic [31:0] rd;
    evt_before = evt_cnt;
    exp_base   = base;
    req_n      = 0;
    reg_write(`CONV_REG_BASE, base);
    reg_write(`CONV_REG_CTRL, 32'h1);
    // busy set, weights ready cleared
    reg_read(`CONV_REG_STATUS, rd);
    if (rd[1:0] !== 2'b10) report_err("STATUS during load", 2, rd[1:0]);
    while (evt_cnt == evt_before) @(negedge clk_fast_i);
    repeat (4) @(negedge clk_fast_i);
    if (evt_cnt != evt_before + 1) report_fail("evt_o did not pulse exactly once for the load");
    if (req_n != 10) report_fail("the load did not read exactly ten memory words");
    reg_read(`CONV_REG_STATUS, rd);
    if (rd[1:0] !== 2'b01) report_err("STATUS after load", 1, rd[1:0]);
  endtask

  // streams n_send pixels of a w x h image and checks every result in order
  task automatic run_frame(input int w, input int h, input int n_send, input int gap_pct,
                           input int ready_pct, input bit big);
    int   sent;
    int   exp;
    logic pix_fire;
    reg_write(`CONV_REG_WIDTH, 32'(w));
    reg_write(`CONV_REG_CTRL, 32'h2);
    img.delete();
    exp_q.delete();
    for (int i = 0; i < n_send; i++) begin
      img.push_back(big ? shortint'($random(seed)) : shortint'(rand_signed(255)));
    end
    for (int y = 2; y < h; y++) begin
      for (int x = 2; x < w; x++) begin
        if (y * w + x < n_send) exp_q.push_back(model_result(w, y, x));
      end
    end
    $display("frame %0dx%0d, %0d pixels, %0d results expected", w, h, n_send, exp_q.size());
    sent     = 0;
    pix_fire = 1'b0;
    while (sent < n_send || exp_q.size() != 0) begin
      @(posedge clk_fast_i);
      #1;
      if (pix_fire) sent++;
      // a pending pixel stays on the bus until taken
      if (pix_fire || !pix_valid_i) begin
        pix_valid_i = (sent < n_send) && (rand_below(100) >= gap_pct);
        pix_data_i  = (sent < n_send) ? img[sent] : '0;
      end
      res_ready_i = rand_below(100) < ready_pct;
      @(negedge clk_fast_i);
      pix_fire = pix_valid_i && pix_ready_o;
      if (res_valid_o && res_ready_i) begin
        results++;
        if (sent < 2 * w + 3) report_fail("result appeared before row 2 of the frame");
        if (exp_q.size() == 0) begin
          report_fail("more results than the frame should produce");
        end else begin
          exp = exp_q.pop_front();
          if (res_data_o !== 16'(exp)) report_err("res_data_o", exp, res_data_o);
        end
        if (cur_relu && res_data_o < 0) report_fail("negative result with relu set");
      end
    end
    @(posedge clk_fast_i);
    #1;
    pix_valid_i = 1'b0;
    res_ready_i = 1'b1;
    repeat (12) begin
      @(negedge clk_fast_i);
      if (res_valid_o) report_fail("extra result after the end of the frame");
    end
  endtask

  ////////////////////////////////////////
  // memory model, random grant and data delays
  ////////////////////////////////////////

  initial begin : mem_model
    int          lat;
    int          word_idx;
    logic        pending;
    logic        req_seen;
    logic [31:0] req_addr;
    shortint     w16;
    lat      = 0;
    word_idx = 0;
    pending  = 1'b0;
    req_seen = 1'b0;
    req_addr = '0;
    forever begin
      @(posedge clk_fast_i);
      #1;
      mem_gnt_i    = 1'b0;
      mem_rvalid_i = 1'b0;
      if (pending) begin
        if (lat == 0) begin
          w16          = (word_idx < 9) ? coef[word_idx] : bias_w;
          mem_rvalid_i = 1'b1;
          // upper half is junk, only the low half is used
          mem_rdata_i  = {16'h5a5a, w16};
          pending      = 1'b0;
        end else begin
          lat--;
        end
      end else if (rst_n && mem_req_o === 1'b1) begin
        // address must stay put while the request waits
        if (req_seen && mem_addr_o !== req_addr) report_err("mem_addr_o", req_addr, mem_addr_o);
        if (rand_below(100) < 60) begin
          if (req_n >= 10) report_fail("more than ten memory reads in one load");
          if (mem_addr_o !== exp_base + 32'(4 * req_n)) begin
            report_err("mem_addr_o", exp_base + 32'(4 * req_n), mem_addr_o);
          end
          mem_gnt_i = 1'b1;
          word_idx  = req_n;
          req_n++;
          pending   = 1'b1;
          lat       = rand_below(4);
          req_seen  = 1'b0;
        end else begin
          req_seen = 1'b1;
          req_addr = mem_addr_o;
        end
      end else begin
        if (req_seen) report_fail("mem_req_o dropped before the grant");
        req_seen = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge clk_fast_i);
    $display("watchdog expired after %0d cycles, the run did not complete", WD_CYCLES);
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin : main
    int w;
    seed          = 5420;
    errors        = 0;
    results       = 0;
    req_n         = 0;
    exp_base      = '0;
    cur_shift     = 0;
    cur_relu      = 1'b0;
    rst_n         = 1'b0;
    apb_psel_i    = 1'b0;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = 1'b0;
    apb_paddr_i   = '0;
    apb_pwdata_i  = '0;
    mem_gnt_i     = 1'b0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    pix_valid_i   = 1'b0;
    pix_data_i    = '0;
    res_ready_i   = 1'b0;
    repeat (4) @(posedge clk_fast_i);
    #1;
    rst_n = 1'b1;

    // outputs idle after reset, then register access
    repeat (2) @(negedge clk_fast_i);
    if (pix_ready_o !== 1'b0) report_err("pix_ready_o", 0, pix_ready_o);
    if (res_valid_o !== 1'b0) report_err("res_valid_o", 0, res_valid_o);
    if (mem_req_o !== 1'b0) report_err("mem_req_o", 0, mem_req_o);
    if (evt_o !== 1'b0) report_err("evt_o", 0, evt_o);
    if (apb_pslverr_o !== 1'b0) report_err("apb_pslverr_o", 0, apb_pslverr_o);
    reg_check(`CONV_REG_STATUS, 32'h0);
    w = $random(seed);
    reg_write(`CONV_REG_BASE, 32'(w));
    reg_check(`CONV_REG_BASE, 32'(w));
    reg_write(`CONV_REG_WIDTH, 32'd37);
    reg_check(`CONV_REG_WIDTH, 32'd37);
    reg_write(`CONV_REG_QF, 32'd3);
    reg_check(`CONV_REG_QF, 32'd3);
    reg_write(`CONV_REG_FLAGS, 32'd1);
    reg_check(`CONV_REG_FLAGS, 32'd1);
    reg_check(`CONV_REG_CTRL, 32'h0);
    expect_slverr(1'b0, 8'h18);
    expect_slverr(1'b1, 8'h1c);
    expect_slverr(1'b1, `CONV_REG_STATUS);
    if (pix_ready_o !== 1'b0) report_err("pix_ready_o", 0, pix_ready_o);

    // weight load, then a plain frame
    set_qf(rand_below(5), 1'b0);
    pick_weights(1'b0);
    load_weights(32'h0000_1000 + 32'(rand_below(64) * 64));
    w = 3 + rand_below(62);
    run_frame(w, 5, w * 5, 0, 100, 1'b0);

    // large values, shift 0, saturation then rectify
    pick_weights(1'b1);
    load_weights(32'h0002_0000 + 32'(rand_below(256) * 4));
    set_qf(0, 1'b0);
    w = 3 + rand_below(62);
    run_frame(w, 4, w * 4, 0, 100, 1'b1);
    set_qf(0, 1'b1);
    run_frame(w, 4, w * 4, 0, 100, 1'b1);

    // input gaps and result back-pressure
    set_qf(rand_below(5), 1'b0);
    pick_weights(1'b0);
    load_weights(32'h0000_4000);
    w = 3 + rand_below(62);
    run_frame(w, 6, w * 6, 40, 50, 1'b0);

    // abandoned partial frame, then a clean restart
    w = 3 + rand_below(62);
    run_frame(w, 4, w + w / 2, 20, 70, 1'b0);
    run_frame(w, 4, w * 4, 20, 70, 1'b0);

    $display("results checked: %0d, errors: %0d", results, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+src
src/conv_pkg.sv
src/stream_skid_buffer.sv
src/conv_cfg_apb.sv
src/conv_weight_loader.sv
src/conv_window_gen.sv
src/conv_sop.sv
src/conv_top.sv
verification/tb_conv_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the 3x3 convolution testbench with Verilator.
# The exit status is nonzero when the build, the run or the result check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_conv_top -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_conv_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
